//--- verilog/tdmr_consts.svh
`ifndef TDMR_CONSTS_SVH
`define TDMR_CONSTS_SVH

// Datapath widths
`define TDMR_DATA_W 32
`define TDMR_ID_W 2
`define TDMR_CNT_W 16
`define TDMR_ADDR_W 4

// Mixing constants, one per pipeline stage
`define TDMR_ROT 5
`define TDMR_KEY 32'h9E37_79B9
`define TDMR_ADD 32'h7F4A_7C15

// APB register offsets
`define TDMR_ADDR_CTRL 4'h0
`define TDMR_ADDR_FAULT 4'h4
`define TDMR_ADDR_FCNT 4'h8
`define TDMR_ADDR_ICNT 4'hC

`endif

//--- verilog/voters.svh
`ifndef VOTERS_SVH
`define VOTERS_SVH

// Bitwise majority of three values
`define MAJ3(a, b, c) (((a) & (b)) | ((a) & (c)) | ((b) & (c)))

// Three voters, one per replica, for vectors
`define VOTE3to3(in, out) \
    out[0] = `MAJ3(in[0], in[1], in[2]); \
    out[1] = `MAJ3(in[0], in[1], in[2]); \
    out[2] = `MAJ3(in[0], in[1], in[2]);

// Single voter for vectors
`define VOTE3to1(in, out) \
    out = `MAJ3(in[0], in[1], in[2]);

// Enums are voted by equality so the result stays a legal value
`define VOTE3to3ENUM(in, out) \
    out[0] = ((in[0] == in[1]) || (in[0] == in[2])) ? in[0] : in[1]; \
    out[1] = ((in[0] == in[1]) || (in[0] == in[2])) ? in[0] : in[1]; \
    out[2] = ((in[0] == in[1]) || (in[0] == in[2])) ? in[0] : in[1];

`endif

//--- verilog/tdmr_pkg.sv
`include "tdmr_consts.svh"

package tdmr_pkg;

    // Sequence ID that ties the two copies of an item together
    typedef logic [`TDMR_ID_W-1:0] id_t;

    // Start stage: pass first copy, hold it, or resend it
    typedef enum logic [1:0] {
        STORE_AND_SEND,
        SEND,
        REPLICATE
    } start_state_t;

    // End stage: nothing held, first copy held, result waiting
    typedef enum logic [1:0] {
        EMPTY,
        HOLD_FIRST,
        OUT_FULL
    } end_state_t;

endpackage

//--- verilog/payload_pkg.sv
`include "tdmr_consts.svh"

package payload_pkg;

    // Data word carried through the lane
    typedef logic [`TDMR_DATA_W-1:0] word_t;

    // APB byte address within the register block
    typedef logic [`TDMR_ADDR_W-1:0] apb_addr_t;

    // Result and fault counts
    typedef logic [`TDMR_CNT_W-1:0] count_t;

endpackage

//--- verilog/time_dmr_start.sv
`timescale 1ns/1ps
`include "voters.svh"

module time_dmr_start (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               enable_i,
    input  payload_pkg::word_t data_i,
    input  logic               valid_i,
    output logic               ready_o,
    output payload_pkg::word_t data_o,
    output tdmr_pkg::id_t      id_o,
    output logic               valid_o,
    input  logic               ready_i
);

    tdmr_pkg::start_state_t state_v [3];
    tdmr_pkg::start_state_t state_d [3];
    tdmr_pkg::start_state_t state_q [3];
    payload_pkg::word_t [2:0] data_v, data_d, data_q;
    tdmr_pkg::id_t [2:0] id_v, id_d, id_q, id_next;
    logic [1:0] state_cur;

    // Each replica computes its own next state from its own registers
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            state_v[r] = state_q[r];
            data_v[r]  = data_q[r];
            id_v[r]    = id_q[r];
            id_next[r] = id_q[r] + 1'b1;

            case (state_q[r])
                tdmr_pkg::STORE_AND_SEND: begin
                    if (valid_i) begin
                        data_v[r] = data_i;
                        id_v[r]   = id_next[r];
                        if (ready_i) begin
                            state_v[r] = enable_i ? tdmr_pkg::REPLICATE
                                                  : tdmr_pkg::STORE_AND_SEND;
                        end else begin
                            state_v[r] = tdmr_pkg::SEND;
                        end
                    end
                end
                tdmr_pkg::SEND: begin
                    if (ready_i) begin
                        state_v[r] = enable_i ? tdmr_pkg::REPLICATE
                                              : tdmr_pkg::STORE_AND_SEND;
                    end
                end
                tdmr_pkg::REPLICATE: begin
                    // Second copy leaves with the same data and ID
                    if (ready_i) begin
                        state_v[r] = tdmr_pkg::STORE_AND_SEND;
                    end
                end
                default: begin
                    state_v[r] = tdmr_pkg::STORE_AND_SEND;
                end
            endcase
        end
    end

    // Vote next values back into all three replicas
    always_comb begin
        `VOTE3to3ENUM(state_v, state_d)
        `VOTE3to3(data_v, data_d)
        `VOTE3to3(id_v, id_d)
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= '{default: tdmr_pkg::STORE_AND_SEND};
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_d;
    end

    // Outputs are taken from voted values only
    always_comb begin
        `VOTE3to1(state_q, state_cur)
        `VOTE3to1(data_v, data_o)
        `VOTE3to1(id_v, id_o)
        ready_o = (state_cur == tdmr_pkg::STORE_AND_SEND);
        valid_o = valid_i || !ready_o;
    end

    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(id_o));

endmodule

//--- verilog/word_mix_pipe.sv
`timescale 1ns/1ps
`include "tdmr_consts.svh"

module word_mix_pipe (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  payload_pkg::word_t data_i,
    input  tdmr_pkg::id_t      id_i,
    input  logic               valid_i,
    output logic               ready_o,
    output payload_pkg::word_t data_o,
    output tdmr_pkg::id_t      id_o,
    output logic               valid_o,
    input  logic               ready_i,
    input  payload_pkg::word_t fault_mask_i,
    input  logic               fault_arm_i,
    output logic               fault_taken_o
);

    logic advance;
    logic v1_q, v2_q, v3_q;
    payload_pkg::word_t d1_q, d2_q, d3_q;
    tdmr_pkg::id_t id1_q, id2_q, id3_q;

    // The whole pipe moves in lockstep when the last stage can drain
    assign advance = !v3_q || ready_i;
    assign ready_o = advance;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else if (advance) begin
            v1_q <= valid_i;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

    // Rotate, then key XOR, then constant add
    always_ff @(posedge clk_i) begin
        if (advance) begin
            d1_q  <= {data_i[`TDMR_DATA_W-`TDMR_ROT-1:0],
                      data_i[`TDMR_DATA_W-1:`TDMR_DATA_W-`TDMR_ROT]};
            d2_q  <= d1_q ^ `TDMR_KEY;
            d3_q  <= d2_q + `TDMR_ADD;
            id1_q <= id_i;
            id2_q <= id1_q;
            id3_q <= id2_q;
        end
    end

    // Injected fault corrupts only the item that leaves while armed
    assign data_o        = fault_arm_i ? (d3_q ^ fault_mask_i) : d3_q;
    assign id_o          = id3_q;
    assign valid_o       = v3_q;
    assign fault_taken_o = fault_arm_i && v3_q && ready_i;

endmodule

//--- verilog/time_dmr_end.sv
`timescale 1ns/1ps

module time_dmr_end (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               enable_i,
    input  payload_pkg::word_t data_i,
    input  tdmr_pkg::id_t      id_i,
    input  logic               valid_i,
    output logic               ready_o,
    output payload_pkg::word_t data_o,
    output logic               fault_o,
    output logic               valid_o,
    input  logic               ready_i,
    output logic               result_fire_o,
    output logic               result_fault_o
);

    tdmr_pkg::end_state_t state_d, state_q;
    payload_pkg::word_t hold_data_q;
    payload_pkg::word_t out_data_d, out_data_q;
    tdmr_pkg::id_t hold_id_q;
    logic out_valid_q;
    logic out_fault_d, out_fault_q;
    logic in_fire, hold_load, out_load;

    // Input only moves when the result register has room
    assign ready_o = !out_valid_q || ready_i;
    assign in_fire = valid_i && ready_o;

    always_comb begin
        state_d     = state_q;
        hold_load   = 1'b0;
        out_load    = 1'b0;
        out_data_d  = data_i;
        out_fault_d = 1'b0;

        case (state_q)
            tdmr_pkg::HOLD_FIRST: begin
                if (in_fire) begin
                    out_load   = 1'b1;
                    out_data_d = hold_data_q;
                    if (id_i == hold_id_q) begin
                        out_fault_d = (data_i != hold_data_q);
                        state_d     = tdmr_pkg::OUT_FULL;
                    end else begin
                        // Partner never came, flag the held copy and keep the new one
                        out_fault_d = 1'b1;
                        hold_load   = 1'b1;
                    end
                end
            end
            default: begin
                // EMPTY and OUT_FULL both take a fresh first copy
                if (in_fire && enable_i) begin
                    hold_load = 1'b1;
                    state_d   = tdmr_pkg::HOLD_FIRST;
                end else if (in_fire) begin
                    out_load = 1'b1;
                    state_d  = tdmr_pkg::OUT_FULL;
                end else if (ready_i) begin
                    state_d = tdmr_pkg::EMPTY;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= tdmr_pkg::EMPTY;
            out_valid_q <= 1'b0;
            out_fault_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (out_load) begin
                out_valid_q <= 1'b1;
                out_fault_q <= out_fault_d;
            end else if (ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold_load) begin
            hold_data_q <= data_i;
            hold_id_q   <= id_i;
        end
        if (out_load) begin
            out_data_q <= out_data_d;
        end
    end

    assign data_o         = out_data_q;
    assign fault_o        = out_fault_q;
    assign valid_o        = out_valid_q;
    assign result_fire_o  = out_valid_q && ready_i;
    assign result_fault_o = out_valid_q && ready_i && out_fault_q;

    // Start stage always sends both copies back to back with one ID
    a_pair_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == tdmr_pkg::HOLD_FIRST && enable_i && valid_i |-> id_i == hold_id_q);

endmodule

//--- verilog/fault_counter.sv
`timescale 1ns/1ps

module fault_counter (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                result_fire_i,
    input  logic                result_fault_i,
    input  logic                clear_faults_i,
    input  logic                clear_items_i,
    output payload_pkg::count_t fault_count_o,
    output payload_pkg::count_t item_count_o
);

    payload_pkg::count_t fault_q, item_q;
    // Set once the two counts no longer start from a common point
    logic unrelated_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fault_q     <= '0;
            item_q      <= '0;
            unrelated_q <= 1'b0;
        end else begin
            if (clear_items_i) begin
                item_q <= '0;
            end else if (result_fire_i) begin
                item_q <= item_q + 1'b1;
            end
            // Fault count sticks at its maximum
            if (clear_faults_i) begin
                fault_q <= '0;
            end else if (result_fire_i && result_fault_i && fault_q != '1) begin
                fault_q <= fault_q + 1'b1;
            end
            if (clear_faults_i || clear_items_i || (result_fire_i && item_q == '1)) begin
                unrelated_q <= 1'b1;
            end
        end
    end

    assign fault_count_o = fault_q;
    assign item_count_o  = item_q;

    a_fault_le_items: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !unrelated_q |-> fault_q <= item_q);

endmodule

//--- verilog/tdmr_apb_regs.sv
`timescale 1ns/1ps
`include "tdmr_consts.svh"

module tdmr_apb_regs (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  payload_pkg::apb_addr_t paddr_i,
    input  payload_pkg::word_t     pwdata_i,
    output payload_pkg::word_t     prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   enable_o,
    output payload_pkg::word_t     fault_mask_o,
    output logic                   fault_arm_o,
    input  logic                   fault_taken_i,
    output logic                   clear_faults_o,
    output logic                   clear_items_o,
    input  payload_pkg::count_t    fault_count_i,
    input  payload_pkg::count_t    item_count_i
);

    logic access, write_en, mapped;
    logic enable_q, fault_arm_q;
    payload_pkg::word_t fault_mask_q;

    // Zero wait states, every access phase completes
    assign access   = psel_i && penable_i;
    assign write_en = access && pwrite_i;
    assign mapped   = (paddr_i == `TDMR_ADDR_CTRL) || (paddr_i == `TDMR_ADDR_FAULT) ||
                      (paddr_i == `TDMR_ADDR_FCNT) || (paddr_i == `TDMR_ADDR_ICNT);
    assign pready_o  = access;
    assign pslverr_o = access && !mapped;

    assign clear_faults_o = write_en && (paddr_i == `TDMR_ADDR_FCNT);
    assign clear_items_o  = write_en && (paddr_i == `TDMR_ADDR_ICNT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q     <= 1'b1;
            fault_mask_q <= '0;
            fault_arm_q  <= 1'b0;
        end else begin
            if (fault_taken_i) begin
                fault_arm_q <= 1'b0;
            end
            if (write_en && paddr_i == `TDMR_ADDR_CTRL) begin
                enable_q <= pwdata_i[0];
            end
            // A zero mask leaves the injector disarmed
            if (write_en && paddr_i == `TDMR_ADDR_FAULT) begin
                fault_mask_q <= pwdata_i;
                fault_arm_q  <= |pwdata_i;
            end
        end
    end

    always_comb begin
        case (paddr_i)
            `TDMR_ADDR_CTRL:  prdata_o = {{(`TDMR_DATA_W - 1){1'b0}}, enable_q};
            `TDMR_ADDR_FAULT: prdata_o = fault_arm_q ? fault_mask_q : '0;
            `TDMR_ADDR_FCNT:  prdata_o = {{(`TDMR_DATA_W - `TDMR_CNT_W){1'b0}}, fault_count_i};
            `TDMR_ADDR_ICNT:  prdata_o = {{(`TDMR_DATA_W - `TDMR_CNT_W){1'b0}}, item_count_i};
            default:          prdata_o = '0;
        endcase
    end

    assign enable_o     = enable_q;
    assign fault_mask_o = fault_mask_q;
    assign fault_arm_o  = fault_arm_q;

    a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_i |-> psel_i);

endmodule

//--- verilog/tdmr_top.sv
`timescale 1ns/1ps

module tdmr_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  payload_pkg::apb_addr_t paddr_i,
    input  payload_pkg::word_t     pwdata_i,
    output payload_pkg::word_t     prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  payload_pkg::word_t     in_data_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    output payload_pkg::word_t     out_data_o,
    output logic                   out_valid_o,
    output logic                   out_fault_o,
    input  logic                   out_ready_i
);

    logic enable, fault_arm, fault_taken;
    logic clear_faults, clear_items, result_fire, result_fault;
    payload_pkg::word_t fault_mask;
    payload_pkg::count_t fault_count, item_count;

    // Start stage to pipe
    payload_pkg::word_t st_data;
    tdmr_pkg::id_t st_id;
    logic st_valid, st_ready;

    // Pipe to end stage
    payload_pkg::word_t mx_data;
    tdmr_pkg::id_t mx_id;
    logic mx_valid, mx_ready;

    time_dmr_start start_inst (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .enable_i (enable),
        .data_i   (in_data_i),
        .valid_i  (in_valid_i),
        .ready_o  (in_ready_o),
        .data_o   (st_data),
        .id_o     (st_id),
        .valid_o  (st_valid),
        .ready_i  (st_ready)
    );

    word_mix_pipe pipe_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_i        (st_data),
        .id_i          (st_id),
        .valid_i       (st_valid),
        .ready_o       (st_ready),
        .data_o        (mx_data),
        .id_o          (mx_id),
        .valid_o       (mx_valid),
        .ready_i       (mx_ready),
        .fault_mask_i  (fault_mask),
        .fault_arm_i   (fault_arm),
        .fault_taken_o (fault_taken)
    );

    time_dmr_end end_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .enable_i       (enable),
        .data_i         (mx_data),
        .id_i           (mx_id),
        .valid_i        (mx_valid),
        .ready_o        (mx_ready),
        .data_o         (out_data_o),
        .fault_o        (out_fault_o),
        .valid_o        (out_valid_o),
        .ready_i        (out_ready_i),
        .result_fire_o  (result_fire),
        .result_fault_o (result_fault)
    );

    fault_counter counter_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .result_fire_i  (result_fire),
        .result_fault_i (result_fault),
        .clear_faults_i (clear_faults),
        .clear_items_i  (clear_items),
        .fault_count_o  (fault_count),
        .item_count_o   (item_count)
    );

    tdmr_apb_regs regs_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .enable_o       (enable),
        .fault_mask_o   (fault_mask),
        .fault_arm_o    (fault_arm),
        .fault_taken_i  (fault_taken),
        .clear_faults_o (clear_faults),
        .clear_items_o  (clear_items),
        .fault_count_i  (fault_count),
        .item_count_i   (item_count)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held for two rising edges, released just after the second
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

//--- sim/tdmr_top_tb.sv
`timescale 1ns/1ps
`include "tdmr_consts.svh"

module tdmr_top_tb;

    localparam int K_WRITE = 0;
    localparam int K_READ = 1;
    localparam int K_SEND = 2;
    localparam int K_MODE = 3;
    localparam int MAX_STEPS = 64;

    logic clk, rst_n;
    logic psel, penable, pwrite;
    payload_pkg::apb_addr_t paddr;
    payload_pkg::word_t pwdata, prdata;
    logic pready, pslverr;
    payload_pkg::word_t in_data, out_data;
    logic in_valid, in_ready, out_valid, out_fault, out_ready;

    // Step table
    int step_kind [MAX_STEPS];
    logic [3:0] step_addr [MAX_STEPS];
    logic [31:0] step_data [MAX_STEPS];
    logic step_err [MAX_STEPS];
    int num_steps = 0;

    // Scoreboard with the oldest result first
    logic [31:0] exp_data_q [$];
    logic exp_fault_q [$];
    int errors = 0;

    // Model of the register state that shapes the next result
    logic model_enable = 1'b1;
    logic model_arm = 1'b0;
    logic [31:0] model_mask = '0;

    logic [15:0] lfsr_q;
    logic random_ready = 1'b0;
    logic ready_bit;

    tb_clock_gen clock_gen_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    tdmr_top tdmr_top_inst (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .in_data_i   (in_data),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_data_o  (out_data),
        .out_valid_o (out_valid),
        .out_fault_o (out_fault),
        .out_ready_i (out_ready)
    );

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bit(output logic b);
        b = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    task automatic random_word(output logic [31:0] w);
        logic b;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            random_bit(b);
            w = {w[30:0], b};
        end
    endtask

    // Rotate left then key XOR then constant add
    function automatic logic [31:0] mix_word(input logic [31:0] w);
        logic [31:0] r;
        r = (w << `TDMR_ROT) | (w >> (32 - `TDMR_ROT));
        r = r ^ `TDMR_KEY;
        mix_word = r + `TDMR_ADD;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: time %0t signal %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic add_step(input int kind, input logic [3:0] addr,
                            input logic [31:0] data, input logic err);
        step_kind[num_steps] = kind;
        step_addr[num_steps] = addr;
        step_data[num_steps] = data;
        step_err[num_steps]  = err;
        num_steps++;
    endtask

    task automatic build_table();
        logic [31:0] w;
        add_step(K_READ, `TDMR_ADDR_CTRL, 32'h1, 1'b0);
        add_step(K_SEND, 4'h0, 32'h0000_0000, 1'b0);
        add_step(K_SEND, 4'h0, 32'hFFFF_FFFF, 1'b0);
        add_step(K_SEND, 4'h0, 32'h1234_5678, 1'b0);
        add_step(K_SEND, 4'h0, 32'h8000_0001, 1'b0);
        add_step(K_READ, `TDMR_ADDR_ICNT, 32'd4, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FCNT, 32'd0, 1'b0);
        // One corrupted copy while redundancy is on
        add_step(K_WRITE, `TDMR_ADDR_FAULT, 32'h0001_0000, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FAULT, 32'h0001_0000, 1'b0);
        add_step(K_SEND, 4'h0, 32'hCAFE_F00D, 1'b0);
        add_step(K_SEND, 4'h0, 32'h0BAD_BEEF, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FAULT, 32'h0, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FCNT, 32'd1, 1'b0);
        add_step(K_READ, `TDMR_ADDR_ICNT, 32'd6, 1'b0);
        // With redundancy off the corruption goes through unflagged
        add_step(K_WRITE, `TDMR_ADDR_CTRL, 32'h0, 1'b0);
        add_step(K_READ, `TDMR_ADDR_CTRL, 32'h0, 1'b0);
        add_step(K_SEND, 4'h0, 32'h1357_9BDF, 1'b0);
        add_step(K_WRITE, `TDMR_ADDR_FAULT, 32'h8000_0003, 1'b0);
        add_step(K_SEND, 4'h0, 32'h2468_ACE0, 1'b0);
        add_step(K_SEND, 4'h0, 32'h55AA_55AA, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FCNT, 32'd1, 1'b0);
        add_step(K_READ, `TDMR_ADDR_ICNT, 32'd9, 1'b0);
        // Random words under random back-pressure
        add_step(K_WRITE, `TDMR_ADDR_CTRL, 32'h1, 1'b0);
        add_step(K_MODE, 4'h0, 32'h1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            random_word(w);
            add_step(K_SEND, 4'h0, w, 1'b0);
        end
        add_step(K_WRITE, `TDMR_ADDR_FAULT, 32'h00F0_0F00, 1'b0);
        for (int i = 0; i < 4; i++) begin
            random_word(w);
            add_step(K_SEND, 4'h0, w, 1'b0);
        end
        add_step(K_MODE, 4'h0, 32'h0, 1'b0);
        add_step(K_READ, `TDMR_ADDR_ICNT, 32'd29, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FCNT, 32'd2, 1'b0);
        add_step(K_WRITE, `TDMR_ADDR_FCNT, 32'h0, 1'b0);
        add_step(K_READ, `TDMR_ADDR_FCNT, 32'd0, 1'b0);
        add_step(K_WRITE, `TDMR_ADDR_ICNT, 32'h0, 1'b0);
        add_step(K_READ, `TDMR_ADDR_ICNT, 32'd0, 1'b0);
        // Unmapped offsets
        add_step(K_WRITE, 4'h2, 32'hFFFF_FFFF, 1'b1);
        add_step(K_READ, 4'h1, 32'h0, 1'b1);
        add_step(K_READ, `TDMR_ADDR_CTRL, 32'h1, 1'b0);
        random_word(w);
        add_step(K_SEND, 4'h0, w, 1'b0);
        add_step(K_READ, `TDMR_ADDR_ICNT, 32'd1, 1'b0);
    endtask

    // Register accesses wait until every sent word has come out
    task automatic wait_idle();
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic apb_access(input logic is_write, input logic [3:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_rdata,
                              input logic exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_equal("pready_o", {31'b0, pready}, 32'h1);
        check_equal("pslverr_o", {31'b0, pslverr}, {31'b0, exp_err});
        if (!is_write) begin
            check_equal("prdata_o", prdata, exp_rdata);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_word(input logic [31:0] word);
        logic [31:0] exp;
        exp = mix_word(word);
        if (model_arm) begin
            exp = exp ^ model_mask;
        end
        exp_data_q.push_back(exp);
        // Only a compare of two copies can raise the flag
        exp_fault_q.push_back(model_enable && model_arm);
        model_arm = 1'b0;
        @(posedge clk);
        #1;
        in_data  = word;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_step(input int s);
        case (step_kind[s])
            K_WRITE: begin
                wait_idle();
                apb_access(1'b1, step_addr[s], step_data[s], 32'h0, step_err[s]);
                if (!step_err[s] && step_addr[s] == `TDMR_ADDR_CTRL) begin
                    model_enable = step_data[s][0];
                end
                if (!step_err[s] && step_addr[s] == `TDMR_ADDR_FAULT) begin
                    model_mask = step_data[s];
                    model_arm  = |step_data[s];
                end
            end
            K_READ: begin
                wait_idle();
                apb_access(1'b0, step_addr[s], 32'h0, step_data[s], step_err[s]);
            end
            K_SEND: begin
                send_word(step_data[s]);
            end
            default: begin
                random_ready = step_data[s][0];
            end
        endcase
    endtask

    // out_ready_i either stays high or takes one LFSR bit per cycle
    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            random_bit(ready_bit);
            out_ready = ready_bit;
        end else begin
            out_ready = 1'b1;
        end
    end

    // Output handshake monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("A result came out that no sent word accounts for at time %0t", $time);
                $display("Simulation FAILED");
                $fatal(1, "unexpected result");
            end else begin
                check_equal("out_data_o", out_data, exp_data_q[0]);
                check_equal("out_fault_o", {31'b0, out_fault}, {31'b0, exp_fault_q[0]});
                void'(exp_data_q.pop_front());
                void'(exp_fault_q.pop_front());
            end
        end
    end

    initial begin
        @(posedge rst_n);
        repeat (num_steps * 200 + 100) @(posedge clk);
        $display("Timeout: the lane stopped delivering results or answering the bus");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int s;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        lfsr_q    = 16'd43867;
        build_table();
        @(posedge rst_n);
        for (s = 0; s < num_steps; s++) begin
            run_step(s);
        end
        wait_idle();
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tdmr_top.f
+incdir+verilog
verilog/tdmr_pkg.sv
verilog/payload_pkg.sv
verilog/time_dmr_start.sv
verilog/word_mix_pipe.sv
verilog/time_dmr_end.sv
verilog/fault_counter.sv
verilog/tdmr_apb_regs.sv
verilog/tdmr_top.sv
sim/tb_clock_gen.sv
sim/tdmr_top_tb.sv
